//--- hdl/eth_base_r_pkg.sv
// Shared definitions for the 10GBASE-R control and test shell
// XGMII widths and character codes, CSR register map,
// transceiver reset hold times and the structs passed between blocks
package eth_base_r_pkg;

    localparam int XGMII_LANES = 8;
    localparam int LEN_W       = 8;
    localparam int CNT_W       = 16;
    localparam int CSR_AW      = 16;
    localparam int CSR_DW      = 32;

    // XGMII characters
    localparam logic [7:0] CH_IDLE     = 8'h07;
    localparam logic [7:0] CH_START    = 8'hFB;
    localparam logic [7:0] CH_TERM     = 8'hFD;
    localparam logic [7:0] CH_ERROR    = 8'hFE;
    localparam logic [7:0] CH_PREAMBLE = 8'h55;
    localparam logic [7:0] CH_SFD      = 8'hD5;

    // Reset sequencer hold times in clock cycles
    localparam int TX_ANALOG_HOLD = 8;
    localparam int RX_ANALOG_HOLD = 8;
    localparam int DIGITAL_HOLD   = 8;
    localparam int LTD_HOLD       = 16;

    // Word addresses, low 3 bits only
    localparam logic [2:0] REG_STATUS    = 3'd0;
    localparam logic [2:0] REG_GEN_CTRL  = 3'd1;
    localparam logic [2:0] REG_GEN_LEN   = 3'd2;
    localparam logic [2:0] REG_GEN_SEED  = 3'd3;
    localparam logic [2:0] REG_MON_GOOD  = 3'd4;
    localparam logic [2:0] REG_MON_BAD   = 3'd5;
    localparam logic [2:0] REG_MON_CLEAR = 3'd6;

    typedef struct packed {
        logic       ctrl;
        logic [7:0] data;
    } xgmii_lane_t;

    // Lane 7 in the top bits, lane 0 first on the wire
    typedef struct packed {
        xgmii_lane_t [XGMII_LANES-1:0] lane;
    } xgmii_word_t;

    typedef struct packed {
        logic              read;
        logic              write;
        logic [CSR_AW-1:0] address;
        logic [CSR_DW-1:0] writedata;
    } csr_req_t;

    typedef struct packed {
        logic [LEN_W-1:0] len;
        logic [7:0]       seed;
    } gen_cfg_t;

    typedef struct packed {
        logic [CNT_W-1:0] good;
        logic [CNT_W-1:0] bad;
    } mon_stats_t;

    typedef struct packed {
        logic tx_ready;
        logic rx_ready;
    } xcvr_status_t;

endpackage

//--- hdl/xcvr_reset_seq.sv
// Transceiver reset sequencer
// TX side follows PLL lock and tx calibration, RX side follows
// the tx analog release, rx calibration and locked-to-data
module xcvr_reset_seq (
    input  logic                        tx_clk_156_i,
    input  logic                        rst_n_i,
    input  logic                        atx_pll_locked_i,
    input  logic                        tx_cal_busy_i,
    input  logic                        rx_cal_busy_i,
    input  logic                        rx_is_lockedtodata_i,
    output logic                        tx_analogreset_o,
    output logic                        tx_digitalreset_o,
    output logic                        rx_analogreset_o,
    output logic                        rx_digitalreset_o,
    output eth_base_r_pkg::xcvr_status_t status_o
);

    typedef enum logic [1:0] {TX_ANALOG, TX_CAL, TX_DIGITAL, TX_DONE} tx_state_t;
    typedef enum logic [1:0] {RX_ANALOG, RX_LTD, RX_DONE} rx_state_t;

    tx_state_t tx_state_q;
    rx_state_t rx_state_q;
    logic [$clog2(eth_base_r_pkg::LTD_HOLD+1)-1:0] tx_cnt_q;
    logic [$clog2(eth_base_r_pkg::LTD_HOLD+1)-1:0] rx_cnt_q;

    always_ff @(posedge tx_clk_156_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_state_q <= TX_ANALOG;
            tx_cnt_q   <= '0;
        end else if (!atx_pll_locked_i) begin
            // Lost lock restarts the whole tx sequence
            tx_state_q <= TX_ANALOG;
            tx_cnt_q   <= '0;
        end else begin
            case (tx_state_q)
                TX_ANALOG: begin
                    tx_cnt_q <= tx_cnt_q + 1'b1;
                    if (tx_cnt_q == eth_base_r_pkg::TX_ANALOG_HOLD - 1) begin
                        tx_state_q <= TX_CAL;
                        tx_cnt_q   <= '0;
                    end
                end
                TX_CAL: begin
                    if (!tx_cal_busy_i) begin
                        tx_state_q <= TX_DIGITAL;
                    end
                end
                TX_DIGITAL: begin
                    tx_cnt_q <= tx_cnt_q + 1'b1;
                    if (tx_cnt_q == eth_base_r_pkg::DIGITAL_HOLD - 1) begin
                        tx_state_q <= TX_DONE;
                    end
                end
                default: tx_state_q <= TX_DONE;
            endcase
        end
    end

    always_ff @(posedge tx_clk_156_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_state_q <= RX_ANALOG;
            rx_cnt_q   <= '0;
        end else if (tx_state_q == TX_ANALOG) begin
            rx_state_q <= RX_ANALOG;
            rx_cnt_q   <= '0;
        end else begin
            case (rx_state_q)
                RX_ANALOG: begin
                    if (rx_cnt_q != eth_base_r_pkg::RX_ANALOG_HOLD - 1) begin
                        rx_cnt_q <= rx_cnt_q + 1'b1;
                    end else if (!rx_cal_busy_i) begin
                        rx_state_q <= RX_LTD;
                        rx_cnt_q   <= '0;
                    end
                end
                RX_LTD: begin
                    // Locked-to-data must hold without a break
                    if (!rx_is_lockedtodata_i) begin
                        rx_cnt_q <= '0;
                    end else if (rx_cnt_q == eth_base_r_pkg::LTD_HOLD - 1) begin
                        rx_state_q <= RX_DONE;
                    end else begin
                        rx_cnt_q <= rx_cnt_q + 1'b1;
                    end
                end
                default: begin
                    if (!rx_is_lockedtodata_i) begin
                        rx_state_q <= RX_LTD;
                        rx_cnt_q   <= '0;
                    end
                end
            endcase
        end
    end

    assign tx_analogreset_o  = tx_state_q == TX_ANALOG;
    assign tx_digitalreset_o = tx_state_q != TX_DONE;
    assign rx_analogreset_o  = rx_state_q == RX_ANALOG;
    assign rx_digitalreset_o = rx_state_q != RX_DONE;
    assign status_o.tx_ready = tx_state_q == TX_DONE;
    assign status_o.rx_ready = rx_state_q == RX_DONE;

    // A ready flag follows the lock it depends on by one cycle at most
    a_ready_needs_lock: assert property (@(posedge tx_clk_156_i) disable iff (!rst_n_i)
        (!status_o.tx_ready || $past(atx_pll_locked_i))
        && (!status_o.rx_ready || $past(rx_is_lockedtodata_i)));

endmodule

//--- hdl/eth_csr_regs.sv
// CSR block
// Word address decode, generator length and seed registers,
// start and clear strobes, registered read-data mux
module eth_csr_regs (
    input  logic                                tx_clk_156_i,
    input  logic                                rst_n_i,
    input  eth_base_r_pkg::csr_req_t            csr_req_i,
    input  logic                                gen_busy_i,
    input  eth_base_r_pkg::mon_stats_t          stats_i,
    input  eth_base_r_pkg::xcvr_status_t        status_i,
    output logic [eth_base_r_pkg::CSR_DW-1:0]   csr_readdata_o,
    output eth_base_r_pkg::gen_cfg_t            cfg_o,
    output logic                                gen_start_o,
    output logic                                mon_clear_o
);

    logic [2:0]                        addr;
    logic [eth_base_r_pkg::CSR_DW-1:0] rd_data;

    assign addr = csr_req_i.address[2:0];

    always_ff @(posedge tx_clk_156_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_o       <= '0;
            gen_start_o <= 1'b0;
            mon_clear_o <= 1'b0;
        end else begin
            gen_start_o <= csr_req_i.write && addr == eth_base_r_pkg::REG_GEN_CTRL
                           && csr_req_i.writedata[0];
            mon_clear_o <= csr_req_i.write && addr == eth_base_r_pkg::REG_MON_CLEAR;
            if (csr_req_i.write && addr == eth_base_r_pkg::REG_GEN_LEN) begin
                cfg_o.len <= csr_req_i.writedata[eth_base_r_pkg::LEN_W-1:0];
            end
            if (csr_req_i.write && addr == eth_base_r_pkg::REG_GEN_SEED) begin
                cfg_o.seed <= csr_req_i.writedata[7:0];
            end
        end
    end

    always_comb begin
        rd_data = '0;
        case (addr)
            eth_base_r_pkg::REG_STATUS: begin
                rd_data[0] = status_i.tx_ready;
                rd_data[1] = status_i.rx_ready;
            end
            eth_base_r_pkg::REG_GEN_CTRL: rd_data[1] = gen_busy_i;
            eth_base_r_pkg::REG_GEN_LEN:  rd_data[eth_base_r_pkg::LEN_W-1:0] = cfg_o.len;
            eth_base_r_pkg::REG_GEN_SEED: rd_data[7:0] = cfg_o.seed;
            eth_base_r_pkg::REG_MON_GOOD: rd_data[eth_base_r_pkg::CNT_W-1:0] = stats_i.good;
            eth_base_r_pkg::REG_MON_BAD:  rd_data[eth_base_r_pkg::CNT_W-1:0] = stats_i.bad;
            default: rd_data = '0;
        endcase
    end

    // Read data holds until the next read
    always_ff @(posedge tx_clk_156_i) begin
        if (csr_req_i.read) begin
            csr_readdata_o <= rd_data;
        end
    end

    a_no_read_write: assert property (@(posedge tx_clk_156_i) disable iff (!rst_n_i)
        !(csr_req_i.read && csr_req_i.write));

endmodule

//--- hdl/xgmii_frame_gen.sv
// XGMII frame generator
// Start word, counting byte payload, terminate word, idles between frames
module xgmii_frame_gen (
    input  logic                        tx_clk_156_i,
    input  logic                        rst_n_i,
    input  eth_base_r_pkg::gen_cfg_t    cfg_i,
    input  logic                        start_i,
    input  logic                        tx_ready_i,
    output logic                        busy_o,
    output eth_base_r_pkg::xgmii_word_t xgmii_tx_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_START, ST_PAYLOAD, ST_TERM} state_t;

    state_t                           state_q;
    logic [eth_base_r_pkg::LEN_W-1:0] words_left_q;
    logic [7:0]                       byte_q;

    always_ff @(posedge tx_clk_156_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= ST_IDLE;
            words_left_q <= '0;
            byte_q       <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    // Starts arriving in any other state are dropped
                    if (start_i && tx_ready_i) begin
                        state_q      <= ST_START;
                        words_left_q <= cfg_i.len;
                        byte_q       <= cfg_i.seed;
                    end
                end
                ST_START: state_q <= ST_PAYLOAD;
                ST_PAYLOAD: begin
                    byte_q <= byte_q + 8'(eth_base_r_pkg::XGMII_LANES);
                    // A length of 0 ends after one word, same as 1
                    if (words_left_q < 2) begin
                        state_q <= ST_TERM;
                    end else begin
                        words_left_q <= words_left_q - 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign busy_o = state_q != ST_IDLE;

    always_comb begin
        for (int i = 0; i < eth_base_r_pkg::XGMII_LANES; i++) begin
            xgmii_tx_o.lane[i].ctrl = 1'b1;
            xgmii_tx_o.lane[i].data = eth_base_r_pkg::CH_IDLE;
        end
        case (state_q)
            ST_START: begin
                for (int i = 1; i < eth_base_r_pkg::XGMII_LANES; i++) begin
                    xgmii_tx_o.lane[i].ctrl = 1'b0;
                    xgmii_tx_o.lane[i].data = eth_base_r_pkg::CH_PREAMBLE;
                end
                xgmii_tx_o.lane[0].data = eth_base_r_pkg::CH_START;
                xgmii_tx_o.lane[eth_base_r_pkg::XGMII_LANES-1].data = eth_base_r_pkg::CH_SFD;
            end
            ST_PAYLOAD: begin
                for (int i = 0; i < eth_base_r_pkg::XGMII_LANES; i++) begin
                    xgmii_tx_o.lane[i].ctrl = 1'b0;
                    xgmii_tx_o.lane[i].data = byte_q + 8'(i);
                end
            end
            ST_TERM: xgmii_tx_o.lane[0].data = eth_base_r_pkg::CH_TERM;
            default: ;
        endcase
    end

    a_start_needs_ready: assert property (@(posedge tx_clk_156_i) disable iff (!rst_n_i)
        (xgmii_tx_o.lane[0].ctrl && xgmii_tx_o.lane[0].data == eth_base_r_pkg::CH_START)
        |-> tx_ready_i);

endmodule

//--- hdl/xgmii_frame_mon.sv
// XGMII frame monitor
// Checks received frames against the counting byte pattern
// and keeps saturating good and bad frame counters
module xgmii_frame_mon (
    input  logic                        tx_clk_156_i,
    input  logic                        rst_n_i,
    input  eth_base_r_pkg::xgmii_word_t xgmii_rx_i,
    input  logic                        xgmii_rx_valid_i,
    input  logic                        clear_i,
    input  logic [7:0]                  seed_i,
    output eth_base_r_pkg::mon_stats_t  stats_o
);

    logic       in_frame_q;
    logic       err_q;
    logic [7:0] exp_q;
    logic       is_start;
    logic       is_term;
    logic       has_err;
    logic       pat_err;
    logic       frame_done;

    always_comb begin
        is_start = xgmii_rx_i.lane[0].ctrl && xgmii_rx_i.lane[0].data == eth_base_r_pkg::CH_START;
        is_term  = xgmii_rx_i.lane[0].ctrl && xgmii_rx_i.lane[0].data == eth_base_r_pkg::CH_TERM;
        has_err  = 1'b0;
        pat_err  = 1'b0;
        for (int i = 0; i < eth_base_r_pkg::XGMII_LANES; i++) begin
            if (xgmii_rx_i.lane[i].ctrl && xgmii_rx_i.lane[i].data == eth_base_r_pkg::CH_ERROR) begin
                has_err = 1'b1;
            end
            if (xgmii_rx_i.lane[i].ctrl || xgmii_rx_i.lane[i].data != exp_q + 8'(i)) begin
                pat_err = 1'b1;
            end
        end
    end

    assign frame_done = xgmii_rx_valid_i && in_frame_q && is_term;

    always_ff @(posedge tx_clk_156_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_frame_q <= 1'b0;
            err_q      <= 1'b0;
            exp_q      <= '0;
        end else if (xgmii_rx_valid_i) begin
            if (is_start) begin
                // A start inside a frame spoils the frame
                in_frame_q <= 1'b1;
                err_q      <= in_frame_q;
                exp_q      <= seed_i;
            end else if (frame_done) begin
                in_frame_q <= 1'b0;
            end else if (in_frame_q) begin
                err_q <= err_q | pat_err | has_err;
                exp_q <= exp_q + 8'(eth_base_r_pkg::XGMII_LANES);
            end
        end
    end

    always_ff @(posedge tx_clk_156_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stats_o <= '0;
        end else if (clear_i) begin
            stats_o <= '0;
        end else if (frame_done) begin
            if (err_q || has_err) begin
                if (stats_o.bad != '1) begin
                    stats_o.bad <= stats_o.bad + 1'b1;
                end
            end else if (stats_o.good != '1) begin
                stats_o.good <= stats_o.good + 1'b1;
            end
        end
    end

    a_one_count: assert property (@(posedge tx_clk_156_i) disable iff (!rst_n_i)
        !(stats_o.good == $past(stats_o.good) + 1'b1 && stats_o.bad == $past(stats_o.bad) + 1'b1));

endmodule

//--- hdl/eth_base_r_top.sv
// Top level of the 10GBASE-R control and test shell
// Reset sequencer, CSR block, frame generator and frame monitor
module eth_base_r_top (
    input  logic                                tx_clk_156_i,
    input  logic                                rst_n_i,
    input  logic                                atx_pll_locked_i,
    input  logic                                tx_cal_busy_i,
    input  logic                                rx_cal_busy_i,
    input  logic                                rx_is_lockedtodata_i,
    input  logic                                xgmii_rx_valid_i,
    input  eth_base_r_pkg::xgmii_word_t         xgmii_rx_i,
    input  eth_base_r_pkg::csr_req_t            csr_req_i,
    output logic                                tx_analogreset_o,
    output logic                                tx_digitalreset_o,
    output logic                                rx_analogreset_o,
    output logic                                rx_digitalreset_o,
    output logic                                tx_ready_export_o,
    output logic                                rx_ready_export_o,
    output eth_base_r_pkg::xgmii_word_t         xgmii_tx_o,
    output logic [eth_base_r_pkg::CSR_DW-1:0]   csr_readdata_o
);

    eth_base_r_pkg::xcvr_status_t status;
    eth_base_r_pkg::gen_cfg_t     gen_cfg;
    eth_base_r_pkg::mon_stats_t   mon_stats;
    logic                         gen_start;
    logic                         gen_busy;
    logic                         mon_clear;

    assign tx_ready_export_o = status.tx_ready;
    assign rx_ready_export_o = status.rx_ready;

    xcvr_reset_seq u_reset_seq (
        .tx_clk_156_i         (tx_clk_156_i),
        .rst_n_i              (rst_n_i),
        .atx_pll_locked_i     (atx_pll_locked_i),
        .tx_cal_busy_i        (tx_cal_busy_i),
        .rx_cal_busy_i        (rx_cal_busy_i),
        .rx_is_lockedtodata_i (rx_is_lockedtodata_i),
        .tx_analogreset_o     (tx_analogreset_o),
        .tx_digitalreset_o    (tx_digitalreset_o),
        .rx_analogreset_o     (rx_analogreset_o),
        .rx_digitalreset_o    (rx_digitalreset_o),
        .status_o             (status)
    );

    eth_csr_regs u_csr_regs (
        .tx_clk_156_i   (tx_clk_156_i),
        .rst_n_i        (rst_n_i),
        .csr_req_i      (csr_req_i),
        .gen_busy_i     (gen_busy),
        .stats_i        (mon_stats),
        .status_i       (status),
        .csr_readdata_o (csr_readdata_o),
        .cfg_o          (gen_cfg),
        .gen_start_o    (gen_start),
        .mon_clear_o    (mon_clear)
    );

    xgmii_frame_gen u_frame_gen (
        .tx_clk_156_i (tx_clk_156_i),
        .rst_n_i      (rst_n_i),
        .cfg_i        (gen_cfg),
        .start_i      (gen_start),
        .tx_ready_i   (status.tx_ready),
        .busy_o       (gen_busy),
        .xgmii_tx_o   (xgmii_tx_o)
    );

    xgmii_frame_mon u_frame_mon (
        .tx_clk_156_i     (tx_clk_156_i),
        .rst_n_i          (rst_n_i),
        .xgmii_rx_i       (xgmii_rx_i),
        .xgmii_rx_valid_i (xgmii_rx_valid_i),
        .clear_i          (mon_clear),
        .seed_i           (gen_cfg.seed),
        .stats_o          (mon_stats)
    );

endmodule

//--- verification/eth_base_r_tb.sv
// Testbench for the 10GBASE-R control and test shell
// Clock and reset, CSR read and write tasks, stimulus table,
// external XGMII loopback with byte error and valid gap insertion,
// Fibonacci LFSR, frame format checker and cycle limit
module eth_base_r_tb;

    typedef struct packed {
        logic [7:0]  len;
        logic [7:0]  seed;
        logic        inject;
        logic        gap;
        logic [15:0] good;
        logic [15:0] bad;
    } row_t;

    // Length, seed, inject error, valid gaps, expected good and bad totals
    row_t rows [7] = '{
        '{8'd1,   8'h00, 1'b0, 1'b0, 16'd1, 16'd0},
        '{8'd4,   8'ha5, 1'b0, 1'b0, 16'd2, 16'd0},
        '{8'd16,  8'h3c, 1'b0, 1'b1, 16'd3, 16'd0},
        '{8'd8,   8'hf0, 1'b1, 1'b0, 16'd3, 16'd1},
        '{8'd0,   8'h11, 1'b0, 1'b0, 16'd4, 16'd1},
        '{8'd32,  8'h7e, 1'b1, 1'b1, 16'd4, 16'd2},
        '{8'd255, 8'hc3, 1'b0, 1'b1, 16'd5, 16'd2}
    };

    logic clk;
    logic rst_n;
    logic pll_locked;
    logic tx_cal_busy;
    logic rx_cal_busy;
    logic ltd;
    logic rx_valid;
    logic tx_ares;
    logic tx_dres;
    logic rx_ares;
    logic rx_dres;
    logic tx_ready;
    logic rx_ready;
    logic [31:0] rdata;
    eth_base_r_pkg::xgmii_word_t rx_word;
    eth_base_r_pkg::xgmii_word_t tx_word;
    eth_base_r_pkg::csr_req_t    csr_req;
    eth_base_r_pkg::xgmii_word_t lb_q [$];

    logic [31:0] lfsr = 32'h8b8d;
    logic [7:0]  cur_seed = 8'h00;
    logic        cur_inject = 1'b0;
    logic        cur_gap = 1'b0;
    int          fr_len = 1;
    int          fr_pos = -1;
    int          frames_seen = 0;
    int          errors = 0;
    int          tests = 0;
    int          failed = 0;
    int          err_at_start = 0;
    string       test_name;

    eth_base_r_top u_eth_base_r_top (
        .tx_clk_156_i         (clk),
        .rst_n_i              (rst_n),
        .atx_pll_locked_i     (pll_locked),
        .tx_cal_busy_i        (tx_cal_busy),
        .rx_cal_busy_i        (rx_cal_busy),
        .rx_is_lockedtodata_i (ltd),
        .xgmii_rx_valid_i     (rx_valid),
        .xgmii_rx_i           (rx_word),
        .csr_req_i            (csr_req),
        .tx_analogreset_o     (tx_ares),
        .tx_digitalreset_o    (tx_dres),
        .rx_analogreset_o     (rx_ares),
        .rx_digitalreset_o    (rx_dres),
        .tx_ready_export_o    (tx_ready),
        .rx_ready_export_o    (rx_ready),
        .xgmii_tx_o           (tx_word),
        .csr_readdata_o       (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic eth_base_r_pkg::xgmii_word_t fill_word(input logic c, input logic [7:0] d);
        eth_base_r_pkg::xgmii_word_t w;
        for (int i = 0; i < 8; i++) begin
            w.lane[i].ctrl = c;
            w.lane[i].data = d;
        end
        return w;
    endfunction

    function automatic eth_base_r_pkg::xgmii_word_t idle_word();
        return fill_word(1'b1, 8'h07);
    endfunction

    function automatic eth_base_r_pkg::xgmii_word_t start_word();
        eth_base_r_pkg::xgmii_word_t w;
        w              = fill_word(1'b0, 8'h55);
        w.lane[0].ctrl = 1'b1;
        w.lane[0].data = 8'hfb;
        w.lane[7].data = 8'hd5;
        return w;
    endfunction

    function automatic eth_base_r_pkg::xgmii_word_t term_word();
        eth_base_r_pkg::xgmii_word_t w;
        w              = idle_word();
        w.lane[0].data = 8'hfd;
        return w;
    endfunction

    // Byte k of the payload is seed plus k
    function automatic eth_base_r_pkg::xgmii_word_t payload_word(input logic [7:0] seed,
                                                                 input int idx);
        eth_base_r_pkg::xgmii_word_t w;
        for (int i = 0; i < 8; i++) begin
            w.lane[i].ctrl = 1'b0;
            w.lane[i].data = seed + 8'(idx * 8 + i);
        end
        return w;
    endfunction

    function automatic int queued_frame_words();
        int n;
        n = 0;
        foreach (lb_q[i]) begin
            if (lb_q[i] != idle_word()) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic int cycle_limit();
        int sum;
        sum = 0;
        foreach (rows[i]) begin
            sum += int'(rows[i].len) + 20;
        end
        return 2 * sum + 200;
    endfunction

    task automatic check_value(input string name, input logic [71:0] got,
                               input logic [71:0] exp);
        assert (got == exp) else begin
            $display("ERR %s: got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        @(negedge clk);
        csr_req.write     = 1'b1;
        csr_req.address   = addr;
        csr_req.writedata = data;
        @(negedge clk);
        csr_req.write = 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [31:0] data);
        @(negedge clk);
        csr_req.read    = 1'b1;
        csr_req.address = addr;
        @(negedge clk);
        csr_req.read = 1'b0;
        data         = rdata;
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        err_at_start = errors;
    endtask

    task automatic finish_test();
        tests++;
        if (errors != err_at_start) begin
            failed++;
            $display("test %0d %s: fail, %0d errors", tests, test_name, errors - err_at_start);
        end else begin
            $display("test %0d %s: pass", tests, test_name);
        end
    endtask

    // Loopback wire with frame format check, runs on every falling edge
    initial begin
        eth_base_r_pkg::xgmii_word_t word;
        logic gap_prev;
        int   inj_word;
        int   inj_lane;
        gap_prev = 1'b0;
        inj_word = -1;
        inj_lane = 0;
        rx_word  = idle_word();
        rx_valid = 1'b0;
        forever begin
            @(negedge clk);
            word = tx_word;
            if (fr_pos < 0) begin
                if (tx_word == start_word()) begin
                    fr_pos = 1;
                    frames_seen++;
                    inj_word = cur_inject ? int'(take_bits(8)) % fr_len : -1;
                    inj_lane = int'(take_bits(3));
                end else begin
                    check_value("xgmii_tx_o idle", tx_word, idle_word());
                end
            end else if (fr_pos <= fr_len) begin
                check_value("xgmii_tx_o payload", tx_word, payload_word(cur_seed, fr_pos - 1));
                if (fr_pos - 1 == inj_word) begin
                    word.lane[inj_lane].data = tx_word.lane[inj_lane].data ^ 8'h5a;
                end
                fr_pos++;
            end else begin
                check_value("xgmii_tx_o terminate", tx_word, term_word());
                fr_pos = -1;
            end
            lb_q.push_back(word);
            if (cur_gap && fr_pos >= 0 && !gap_prev && take_bits(1) == 1) begin
                // Invalid cycle carries error characters the monitor must skip
                gap_prev = 1'b1;
                rx_valid = 1'b0;
                rx_word  = fill_word(1'b1, 8'hfe);
            end else begin
                // Idles soak up the latency the gaps added
                while (lb_q.size() > 1 && lb_q[0] == idle_word()) begin
                    void'(lb_q.pop_front());
                end
                gap_prev = 1'b0;
                rx_valid = 1'b1;
                rx_word  = lb_q.pop_front();
            end
        end
    end

    initial begin
        int limit;
        int cycles;
        limit  = cycle_limit();
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles without finishing", cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [31:0] data;
        int          seen;
        rst_n       = 1'b0;
        pll_locked  = 1'b0;
        tx_cal_busy = 1'b1;
        rx_cal_busy = 1'b1;
        ltd         = 1'b0;
        csr_req     = '0;
        repeat (2) @(negedge clk);

        begin_test("reset state and bring-up");
        check_value("tx_analogreset_o", tx_ares, 1);
        check_value("rx_analogreset_o", rx_ares, 1);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("tx_digitalreset_o", tx_dres, 1);
        check_value("rx_digitalreset_o", rx_dres, 1);
        check_value("tx_ready_export_o", tx_ready, 0);
        check_value("rx_ready_export_o", rx_ready, 0);
        pll_locked  = 1'b1;
        tx_cal_busy = 1'b0;
        rx_cal_busy = 1'b0;
        ltd         = 1'b1;
        while (!(tx_ready && rx_ready)) @(negedge clk);
        check_value("rx_digitalreset_o", rx_dres, 0);
        check_value("tx_digitalreset_o", tx_dres, 0);
        check_value("tx_analogreset_o", tx_ares, 0);
        check_value("rx_analogreset_o", rx_ares, 0);
        read_reg(16'd0, data);
        check_value("STATUS", data, 32'h3);
        read_reg(16'd1, data);
        check_value("GEN_CTRL", data, 32'h0);
        read_reg(16'd4, data);
        check_value("MON_GOOD", data, 32'h0);
        read_reg(16'd5, data);
        check_value("MON_BAD", data, 32'h0);
        finish_test();

        begin_test("loss of lock");
        ltd = 1'b0;
        while (!rx_dres) @(negedge clk);
        check_value("rx_ready_export_o", rx_ready, 0);
        read_reg(16'd0, data);
        check_value("STATUS", data, 32'h1);
        ltd = 1'b1;
        while (!rx_ready) @(negedge clk);
        check_value("rx_digitalreset_o", rx_dres, 0);
        read_reg(16'd0, data);
        check_value("STATUS", data, 32'h3);
        finish_test();

        for (int r = 0; r < $size(rows); r++) begin
            begin_test($sformatf("frame row %0d length %0d", r, rows[r].len));
            cur_seed   = rows[r].seed;
            fr_len     = (rows[r].len == 0) ? 1 : int'(rows[r].len);
            cur_inject = rows[r].inject;
            cur_gap    = rows[r].gap;
            seen       = frames_seen;
            write_reg(16'd2, {24'h0, rows[r].len});
            write_reg(16'd3, {24'h0, rows[r].seed});
            read_reg(16'd2, data);
            check_value("GEN_LEN", data, {24'h0, rows[r].len});
            read_reg(16'd3, data);
            check_value("GEN_SEED", data, {24'h0, rows[r].seed});
            write_reg(16'd1, 32'h1);
            do begin
                read_reg(16'd1, data);
            end while (data[1]);
            do @(posedge clk); while (queued_frame_words() != 0);
            read_reg(16'd4, data);
            check_value("MON_GOOD", data, {16'h0, rows[r].good});
            read_reg(16'd5, data);
            check_value("MON_BAD", data, {16'h0, rows[r].bad});
            assert (frames_seen == seen + 1) else begin
                $display("expected one frame on xgmii_tx_o, saw %0d", frames_seen - seen);
                errors++;
            end
            finish_test();
        end

        begin_test("register access");
        read_reg(16'd7, data);
        check_value("address 7", data, 32'h0);
        read_reg(16'hfff7, data);
        check_value("address fff7", data, 32'h0);
        write_reg(16'd2, 32'hffff_ff5c);
        read_reg(16'd2, data);
        check_value("GEN_LEN", data, 32'h5c);
        write_reg(16'd3, 32'h1234_56a7);
        read_reg(16'd3, data);
        check_value("GEN_SEED", data, 32'ha7);
        write_reg(16'd6, 32'h1);
        read_reg(16'd4, data);
        check_value("MON_GOOD", data, 32'h0);
        read_reg(16'd5, data);
        check_value("MON_BAD", data, 32'h0);
        finish_test();

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- eth_base_r.f
hdl/eth_base_r_pkg.sv
hdl/xcvr_reset_seq.sv
hdl/eth_csr_regs.sv
hdl/xgmii_frame_gen.sv
hdl/xgmii_frame_mon.sv
hdl/eth_base_r_top.sv
verification/eth_base_r_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it
# The run passes only if the pass line appears in the output
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module eth_base_r_tb \
    -f eth_base_r.f -o eth_base_r_sim &&
./obj_dir/eth_base_r_sim | tee /dev/stderr | grep -qx "TEST OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
